//--- leaf_macros.svh
`ifndef LEAF_MACROS_SVH
`define LEAF_MACROS_SVH

////////////////////////////////////////////////////////////
// network packet widths.
////////////////////////////////////////////////////////////

`define LEAF_PACKET_BITS   49
`define LEAF_PAYLOAD_BITS  32
`define LEAF_NUM_LEAF_BITS 5
`define LEAF_NUM_PORT_BITS 4
`define LEAF_NUM_ADDR_BITS 7

////////////////////////////////////////////////////////////
// leaf geometry.
////////////////////////////////////////////////////////////

// user ports per direction.
`define LEAF_NUM_PORTS 4

// entries in each user-bound queue.
`define LEAF_FIFO_DEPTH 8

`endif

//--- leaf_pkg.sv
`include "leaf_macros.svh"

package leaf_pkg;

    typedef logic [`LEAF_PAYLOAD_BITS-1:0]  payload_t;
    typedef logic [`LEAF_NUM_LEAF_BITS-1:0] leaf_addr_t;
    typedef logic [`LEAF_NUM_PORT_BITS-1:0] port_addr_t;
    typedef logic [`LEAF_NUM_ADDR_BITS-1:0] seq_t;

    // msb first, as it sits on the wire.
    typedef struct packed {
        logic       valid;
        leaf_addr_t leaf;
        port_addr_t port;
        seq_t       seq;
        payload_t   payload;
    } packet_t;

    // one destination table entry.
    typedef struct packed {
        leaf_addr_t leaf;
        port_addr_t port;
    } dest_t;

    // port 0 carries configuration writes.
    localparam port_addr_t CFG_PORT = '0;

endpackage

//--- leaf_fifo.sv
`include "leaf_macros.svh"

module leaf_fifo
    import leaf_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     empty,
    output logic     full
);

    localparam int ADDR_BITS = $clog2(`LEAF_FIFO_DEPTH);

    payload_t             mem [`LEAF_FIFO_DEPTH];
    logic [ADDR_BITS-1:0] wr_ptr;
    logic [ADDR_BITS-1:0] rd_ptr;
    logic [ADDR_BITS:0]   count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither.
            endcase
        end
    end

    // head word, valid whenever not empty.
    assign dout  = mem[rd_ptr];
    assign empty = (count == 0);
    assign full  = (count == `LEAF_FIFO_DEPTH);

    ////////////////////////////////////////////////////////////
    // the network has no back-pressure, the sender must pace itself.
    ////////////////////////////////////////////////////////////

    a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full))
        else $error("leaf_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else $error("leaf_fifo: pop while empty");

endmodule

//--- leaf_rx_unpack.sv
`include "leaf_macros.svh"

module leaf_rx_unpack
    import leaf_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  packet_t                           din,
    output logic [`LEAF_NUM_PORTS-1:0]         q_push,
    output payload_t                          q_data,
    output logic                              cfg_wr,
    output logic [$clog2(`LEAF_NUM_PORTS)-1:0] cfg_index,
    output dest_t                             cfg_dest
);

    localparam int IDX_BITS = $clog2(`LEAF_NUM_PORTS);

    ////////////////////////////////////////////////////////////
    // data packets, ports 1..4 map to queues 0..3.
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `LEAF_NUM_PORTS; i++) begin
            q_push[i] = din.valid && (din.port == port_addr_t'(i + 1));
        end
    end

    // same word goes to every queue, the strobe picks one.
    assign q_data = din.payload;

    ////////////////////////////////////////////////////////////
    // configuration packets.
    ////////////////////////////////////////////////////////////

    assign cfg_wr = din.valid && (din.port == CFG_PORT);

    // payload layout of a config write.
    assign cfg_index     = din.payload[IDX_BITS-1:0];
    assign cfg_dest.leaf = din.payload[8 +: `LEAF_NUM_LEAF_BITS];  // bits 12:8.
    assign cfg_dest.port = din.payload[16 +: `LEAF_NUM_PORT_BITS]; // bits 19:16.

    // packets above the last port are dropped.
    a_port_range: assert property (
        @(posedge clk) disable iff (reset)
        din.valid |-> (din.port <= port_addr_t'(`LEAF_NUM_PORTS))
    ) else $error("leaf_rx_unpack: packet to unknown port %0d", din.port);

endmodule

//--- leaf_tx_pack.sv
`include "leaf_macros.svh"

module leaf_tx_pack
    import leaf_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              resend,
    input  logic [`LEAF_NUM_PORTS-1:0]         vld_user,
    input  payload_t                          data_user [`LEAF_NUM_PORTS],
    output logic [`LEAF_NUM_PORTS-1:0]         ack_user,
    input  logic                              cfg_wr,
    input  logic [$clog2(`LEAF_NUM_PORTS)-1:0] cfg_index,
    input  dest_t                             cfg_dest,
    output packet_t                           dout
);

    localparam int IDX_BITS = $clog2(`LEAF_NUM_PORTS);

    logic                arb_en;   // low for the first cycle out of reset.
    logic [IDX_BITS-1:0] last_ptr;
    logic [IDX_BITS-1:0] gnt_idx;
    logic                gnt_any;
    logic                take;
    dest_t               dest_tab [`LEAF_NUM_PORTS];
    seq_t                seq_cnt [`LEAF_NUM_PORTS];
    packet_t             pkt_next;
    packet_t             dout_q;

    ////////////////////////////////////////////////////////////
    // round robin search starts just after the last grant.
    ////////////////////////////////////////////////////////////

    always_comb begin
        logic [IDX_BITS-1:0] idx;
        gnt_idx = '0;
        gnt_any = 1'b0;
        for (int k = 1; k <= `LEAF_NUM_PORTS; k++) begin
            idx = last_ptr + IDX_BITS'(k);
            if (!gnt_any && vld_user[idx]) begin
                gnt_idx = idx;
                gnt_any = 1'b1;
            end
        end
    end

    assign take     = gnt_any && arb_en && !resend;
    assign ack_user = take ? (`LEAF_NUM_PORTS'(1) << gnt_idx) : '0;

    // stamp destination and running count.
    always_comb begin
        pkt_next.valid   = 1'b1;
        pkt_next.leaf    = dest_tab[gnt_idx].leaf;
        pkt_next.port    = dest_tab[gnt_idx].port;
        pkt_next.seq     = seq_cnt[gnt_idx];
        pkt_next.payload = data_user[gnt_idx];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arb_en   <= 1'b0;
            last_ptr <= IDX_BITS'(`LEAF_NUM_PORTS - 1); // port 0 wins first.
            dout_q   <= '0;
            for (int i = 0; i < `LEAF_NUM_PORTS; i++) begin
                dest_tab[i] <= '0;
                seq_cnt[i]  <= '0;
            end
        end else begin
            arb_en <= 1'b1;
            if (cfg_wr) begin
                dest_tab[cfg_index] <= cfg_dest;
            end
            if (take) begin
                last_ptr         <= gnt_idx;
                seq_cnt[gnt_idx] <= seq_cnt[gnt_idx] + 1'b1; // wraps at 128.
            end
            dout_q <= take ? pkt_next : '0;
        end
    end

    // network sees zeros while a resend is going on.
    assign dout = resend ? '0 : dout_q;

    a_ack_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(ack_user))
        else $error("leaf_tx_pack: more than one user port acked");

endmodule

//--- leaf_i4o4.sv
`include "leaf_macros.svh"

module leaf_i4o4
    import leaf_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     resend,
    input  packet_t  din_leaf_bft2interface,
    output packet_t  dout_leaf_interface2bft,

    output payload_t dout_leaf_interface2user_1,
    output payload_t dout_leaf_interface2user_2,
    output payload_t dout_leaf_interface2user_3,
    output payload_t dout_leaf_interface2user_4,
    output logic     vld_interface2user_1,
    output logic     vld_interface2user_2,
    output logic     vld_interface2user_3,
    output logic     vld_interface2user_4,
    input  logic     ack_user2interface_1,
    input  logic     ack_user2interface_2,
    input  logic     ack_user2interface_3,
    input  logic     ack_user2interface_4,

    input  payload_t din_leaf_user2interface_1,
    input  payload_t din_leaf_user2interface_2,
    input  payload_t din_leaf_user2interface_3,
    input  payload_t din_leaf_user2interface_4,
    input  logic     vld_user2interface_1,
    input  logic     vld_user2interface_2,
    input  logic     vld_user2interface_3,
    input  logic     vld_user2interface_4,
    output logic     ack_interface2user_1,
    output logic     ack_interface2user_2,
    output logic     ack_interface2user_3,
    output logic     ack_interface2user_4
);

    logic [`LEAF_NUM_PORTS-1:0]         q_push;
    payload_t                          q_data;
    logic [`LEAF_NUM_PORTS-1:0]         q_pop;
    logic [`LEAF_NUM_PORTS-1:0]         q_empty;
    payload_t                          q_dout [`LEAF_NUM_PORTS];
    logic [`LEAF_NUM_PORTS-1:0]         user_ack;
    logic                              cfg_wr;
    logic [$clog2(`LEAF_NUM_PORTS)-1:0] cfg_index;
    dest_t                             cfg_dest;
    logic [`LEAF_NUM_PORTS-1:0]         tx_vld;
    payload_t                          tx_data [`LEAF_NUM_PORTS];
    logic [`LEAF_NUM_PORTS-1:0]         tx_ack;

    ////////////////////////////////////////////////////////////
    // network to user.
    ////////////////////////////////////////////////////////////

    leaf_rx_unpack rx_unpack_inst (
        .clk       (clk),
        .reset     (reset),
        .din       (din_leaf_bft2interface),
        .q_push    (q_push),
        .q_data    (q_data),
        .cfg_wr    (cfg_wr),
        .cfg_index (cfg_index),
        .cfg_dest  (cfg_dest)
    );

    assign user_ack = {ack_user2interface_4, ack_user2interface_3,
                       ack_user2interface_2, ack_user2interface_1};
    assign q_pop    = user_ack & ~q_empty; // ack without vld is ignored.

    for (genvar i = 0; i < `LEAF_NUM_PORTS; i++) begin : g_rx_queue
        leaf_fifo fifo_inst (
            .clk   (clk),
            .reset (reset),
            .push  (q_push[i]),
            .din   (q_data),
            .pop   (q_pop[i]),
            .dout  (q_dout[i]),
            .empty (q_empty[i]),
            .full  ()
        );
    end

    assign dout_leaf_interface2user_1 = q_dout[0];
    assign dout_leaf_interface2user_2 = q_dout[1];
    assign dout_leaf_interface2user_3 = q_dout[2];
    assign dout_leaf_interface2user_4 = q_dout[3];
    assign {vld_interface2user_4, vld_interface2user_3,
            vld_interface2user_2, vld_interface2user_1} = ~q_empty;

    ////////////////////////////////////////////////////////////
    // user to network.
    ////////////////////////////////////////////////////////////

    assign tx_vld     = {vld_user2interface_4, vld_user2interface_3,
                         vld_user2interface_2, vld_user2interface_1};
    assign tx_data[0] = din_leaf_user2interface_1;
    assign tx_data[1] = din_leaf_user2interface_2;
    assign tx_data[2] = din_leaf_user2interface_3;
    assign tx_data[3] = din_leaf_user2interface_4;

    leaf_tx_pack tx_pack_inst (
        .clk       (clk),
        .reset     (reset),
        .resend    (resend),
        .vld_user  (tx_vld),
        .data_user (tx_data),
        .ack_user  (tx_ack),
        .cfg_wr    (cfg_wr),
        .cfg_index (cfg_index),
        .cfg_dest  (cfg_dest),
        .dout      (dout_leaf_interface2bft)
    );

    assign {ack_interface2user_4, ack_interface2user_3,
            ack_interface2user_2, ack_interface2user_1} = tx_ack;

endmodule

//--- tb_leaf_i4o4.sv
`include "leaf_macros.svh"

module tb_leaf_i4o4
    import leaf_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED        = 65091;
    localparam int RX_WORDS    = 600;
    localparam int TX_PER_PORT = 150;
    localparam int TX_WORDS    = TX_PER_PORT * `LEAF_NUM_PORTS;
    // about three cycles per word each way plus margin for reset.
    localparam int TIMEOUT_CYCLES = 3 * (RX_WORDS + TX_WORDS) + 400;

    logic                       clk;
    logic                       reset;
    logic                       resend;
    packet_t                    net_in;
    packet_t                    net_out;
    payload_t                   user_out [`LEAF_NUM_PORTS];
    logic [`LEAF_NUM_PORTS-1:0] user_vld;
    logic [`LEAF_NUM_PORTS-1:0] user_ack;
    payload_t                   tx_data [`LEAF_NUM_PORTS];
    logic [`LEAF_NUM_PORTS-1:0] tx_vld;
    logic [`LEAF_NUM_PORTS-1:0] tx_ack;

    // model state.
    payload_t                   rx_q [`LEAF_NUM_PORTS][$]; // words owed to each user port.
    packet_t                    net_q [$];                 // packets due next cycle.
    dest_t                      dest_tab [`LEAF_NUM_PORTS];
    seq_t                       seq_cnt [`LEAF_NUM_PORTS];
    logic [1:0]                 last_gnt;
    logic                       arb_ready;
    logic [`LEAF_NUM_PORTS-1:0] tx_taken;
    int                         tx_offered [`LEAF_NUM_PORTS];
    int                         rx_sent;
    int                         tx_sent;
    int                         cycles;

    leaf_i4o4 dut0 (
        .clk(clk), .reset(reset), .resend(resend),
        .din_leaf_bft2interface(net_in), .dout_leaf_interface2bft(net_out),
        .dout_leaf_interface2user_1(user_out[0]), .dout_leaf_interface2user_2(user_out[1]),
        .dout_leaf_interface2user_3(user_out[2]), .dout_leaf_interface2user_4(user_out[3]),
        .vld_interface2user_1(user_vld[0]), .vld_interface2user_2(user_vld[1]),
        .vld_interface2user_3(user_vld[2]), .vld_interface2user_4(user_vld[3]),
        .ack_user2interface_1(user_ack[0]), .ack_user2interface_2(user_ack[1]),
        .ack_user2interface_3(user_ack[2]), .ack_user2interface_4(user_ack[3]),
        .din_leaf_user2interface_1(tx_data[0]), .din_leaf_user2interface_2(tx_data[1]),
        .din_leaf_user2interface_3(tx_data[2]), .din_leaf_user2interface_4(tx_data[3]),
        .vld_user2interface_1(tx_vld[0]), .vld_user2interface_2(tx_vld[1]),
        .vld_user2interface_3(tx_vld[2]), .vld_user2interface_4(tx_vld[3]),
        .ack_interface2user_1(tx_ack[0]), .ack_interface2user_2(tx_ack[1]),
        .ack_interface2user_3(tx_ack[2]), .ack_interface2user_4(tx_ack[3])
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // compare tasks.
    ////////////////////////////////////////////////////////////

    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_payload(string name, payload_t got, payload_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_packet(string name, packet_t got, packet_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flags(string name, logic [`LEAF_NUM_PORTS-1:0] got,
                               logic [`LEAF_NUM_PORTS-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus and model.
    ////////////////////////////////////////////////////////////

    task automatic drive_inputs();
        int         r;
        logic [1:0] p;
        tx_vld   = tx_vld & ~tx_taken; // acked words leave the user side.
        tx_taken = '0;
        for (int i = 0; i < `LEAF_NUM_PORTS; i++) begin
            if (!tx_vld[i] && tx_offered[i] < TX_PER_PORT && $urandom_range(99) < 50) begin
                tx_vld[i]  = 1'b1;
                tx_data[i] = payload_t'($urandom());
                tx_offered[i]++;
            end
        end
        net_in = '0;
        r      = int'($urandom_range(99));
        p      = 2'($urandom());
        if (r < 8) begin
            net_in.valid   = 1'b1;
            net_in.port    = CFG_PORT;
            net_in.seq     = seq_t'($urandom());
            net_in.payload = payload_t'($urandom());
        end else if (r < 75 && rx_sent < RX_WORDS && rx_q[p].size() < `LEAF_FIFO_DEPTH) begin
            net_in.valid   = 1'b1;
            net_in.leaf    = leaf_addr_t'($urandom());
            net_in.port    = port_addr_t'(p) + 1'b1;
            net_in.seq     = seq_t'($urandom());
            net_in.payload = payload_t'($urandom());
            rx_sent++;
        end
        user_ack = 4'($urandom());
        // resend only starts once the last accepted word is out.
        if (resend) resend = ($urandom_range(99) < 60);
        else resend = (net_q.size() == 0) && ($urandom_range(99) < 5);
    endtask

    task automatic sample_outputs();
        packet_t                    exp_pkt;
        logic [`LEAF_NUM_PORTS-1:0] exp_vld;
        logic [`LEAF_NUM_PORTS-1:0] exp_ack;
        logic [1:0]                 idx;
        dest_t                      cfg;
        exp_pkt = '0;
        if (net_q.size() != 0) exp_pkt = net_q.pop_front();
        check_packet("dout_leaf_interface2bft", net_out, exp_pkt);
        for (int i = 0; i < `LEAF_NUM_PORTS; i++) begin
            exp_vld[i] = (rx_q[i].size() != 0);
        end
        check_flags("vld_interface2user", user_vld, exp_vld);
        for (int i = 0; i < `LEAF_NUM_PORTS; i++) begin
            if (exp_vld[i] && user_ack[i]) begin
                check_payload($sformatf("dout_leaf_interface2user_%0d", i + 1),
                              user_out[i], rx_q[i].pop_front());
            end
        end
        // round robin from the port after the last grant.
        exp_ack = '0;
        if (arb_ready && !resend) begin
            for (int k = 1; k <= `LEAF_NUM_PORTS; k++) begin
                idx = last_gnt + 2'(k);
                if (exp_ack == '0 && tx_vld[idx]) exp_ack[idx] = 1'b1;
            end
        end
        check_flags("ack_interface2user", tx_ack, exp_ack);
        for (int i = 0; i < `LEAF_NUM_PORTS; i++) begin
            if (exp_ack[i]) begin
                exp_pkt.valid   = 1'b1;
                exp_pkt.leaf    = dest_tab[i].leaf;
                exp_pkt.port    = dest_tab[i].port;
                exp_pkt.seq     = seq_cnt[i];
                exp_pkt.payload = tx_data[i];
                net_q.push_back(exp_pkt);
                seq_cnt[i]  = seq_cnt[i] + 1'b1;
                last_gnt    = 2'(i);
                tx_taken[i] = 1'b1;
                tx_sent++;
            end
        end
        // table change counts from the next accepted word.
        if (net_in.valid && net_in.port == CFG_PORT) begin
            cfg.leaf = net_in.payload[12:8];
            cfg.port = net_in.payload[19:16];
            dest_tab[net_in.payload[1:0]] = cfg;
        end else if (net_in.valid) begin
            rx_q[int'(net_in.port) - 1].push_back(net_in.payload);
        end
        arb_ready = 1'b1;
    endtask

    function automatic bit traffic_drained();
        bit drained;
        drained = (rx_sent == RX_WORDS) && (tx_sent == TX_WORDS) && (net_q.size() == 0);
        for (int i = 0; i < `LEAF_NUM_PORTS; i++) begin
            if (rx_q[i].size() != 0) drained = 1'b0;
        end
        return drained;
    endfunction

    initial begin
        void'($urandom(SEED));
        reset     = 1'b1;
        resend    = 1'b0;
        net_in    = '0;
        user_ack  = '0;
        tx_vld    = '0;
        tx_taken  = '0;
        last_gnt  = 2'd3; // port 1 wins first.
        arb_ready = 1'b0;
        rx_sent   = 0;
        tx_sent   = 0;
        for (int i = 0; i < `LEAF_NUM_PORTS; i++) begin
            tx_data[i]    = '0;
            tx_offered[i] = 0;
            dest_tab[i]   = '0;
            seq_cnt[i]    = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (!traffic_drained()) begin
            drive_inputs();
            #5;
            sample_outputs();
            @(negedge clk);
        end
        $display("All tests passed");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with traffic still pending", cycles);
        stop_on_failure();
    end

endmodule

//--- sources.f
+incdir+.
leaf_pkg.sv
leaf_fifo.sv
leaf_rx_unpack.sv
leaf_tx_pack.sv
leaf_i4o4.sv
tb_leaf_i4o4.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_leaf_i4o4
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) leaf_macros.svh

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
